/* hw/fifo_pkg.sv */
`default_nettype none

package fifo_pkg;

    // lane geometry, fixed so the union below has a known size
    localparam int LANE_WIDTH = 8;
    localparam int LANE_COUNT = 4;
    localparam int LANE_BITS  = 2;
    localparam int WIDE_WIDTH = LANE_COUNT * LANE_WIDTH;

    // one read word
    typedef logic [LANE_WIDTH-1:0] lane_t;

    // lane index within a wide word
    typedef logic [LANE_BITS-1:0] lane_idx_t;

    // one write word, seen whole or as lanes
    // lanes[LANE_COUNT-1] is the most significant lane
    typedef union packed {
        logic [WIDE_WIDTH-1:0]   flat;
        lane_t [LANE_COUNT-1:0]  lanes;
    } wide_word_t;

endpackage

`default_nettype wire

/* hw/fifo_ram_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface fifo_ram_if #(
    parameter int ADDR_WIDTH = 4
);

    import fifo_pkg::*;

    // write port, one whole wide word per strobe
    logic                  wr_en;
    logic [ADDR_WIDTH-1:0] wr_addr;
    wide_word_t            wr_data;

    // read port, one lane of the addressed word per strobe
    logic                  rd_en;
    logic [ADDR_WIDTH-1:0] rd_addr;
    lane_idx_t             rd_lane;

    modport ctrl (
        output wr_en, wr_addr, wr_data,
        output rd_en, rd_addr, rd_lane
    );

    modport ram (
        input wr_en, wr_addr, wr_data,
        input rd_en, rd_addr, rd_lane
    );

endinterface

`default_nettype wire

/* hw/fifo_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module fifo_ctrl #(
    parameter int WR_DEPTH = 16
) (
    input  wire                                               clock,
    input  wire                                               sys_rst,

    input  wire                                               wr_en,
    input  fifo_pkg::wide_word_t                              din,
    output logic                                              wr_ready,

    input  wire                                               rd_en,
    output logic                                              valid,

    output logic                                              full,
    output logic                                              empty,

    output logic [$clog2(WR_DEPTH):0]                         wr_data_count,
    output logic [$clog2(WR_DEPTH):0]                         wr_data_space,
    output logic [$clog2(WR_DEPTH*fifo_pkg::LANE_COUNT):0]    rd_data_count,
    output logic [$clog2(WR_DEPTH*fifo_pkg::LANE_COUNT):0]    rd_data_space,

    fifo_ram_if.ctrl                                          ram
);

    import fifo_pkg::*;

    localparam int ADDR_W    = $clog2(WR_DEPTH);
    localparam int RD_ADDR_W = ADDR_W + LANE_BITS;
    localparam int RD_DEPTH  = WR_DEPTH * LANE_COUNT;
    localparam int WR_CNT_W  = ADDR_W + 1;
    localparam int RD_CNT_W  = RD_ADDR_W + 1;

    // wide word pointer with wrap bit on top
    logic [ADDR_W:0]    wr_ptr;

    // lane pointer: wrap bit, word address, lane field
    logic [RD_ADDR_W:0] rd_ptr;

    // word part of the read pointer, address plus wrap bit
    logic [ADDR_W:0]    rd_word;

    logic               wr_accept;
    logic               rd_accept;

    assign rd_word = rd_ptr[RD_ADDR_W:LANE_BITS];

    // flags straight from the pointer registers
    assign empty = (wr_ptr == rd_word);
    assign full  = (wr_ptr[ADDR_W-1:0] == rd_word[ADDR_W-1:0]) &&
                   (wr_ptr[ADDR_W] != rd_word[ADDR_W]);

    assign wr_ready = ~full;

    // requests against the flags
    assign wr_accept = wr_en & ~full;
    assign rd_accept = rd_en & ~empty;

    always_ff @(posedge clock or negedge sys_rst) begin
        if (!sys_rst) begin
            wr_ptr <= '0;
        end else if (wr_accept) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    // lane field carries into the word address after the last lane
    always_ff @(posedge clock or negedge sys_rst) begin
        if (!sys_rst) begin
            rd_ptr <= '0;
        end else if (rd_accept) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

    // data shows one cycle after the accepting edge
    always_ff @(posedge clock or negedge sys_rst) begin
        if (!sys_rst) begin
            valid <= 1'b0;
        end else begin
            valid <= rd_accept;
        end
    end

    // a partly read word still counts as stored
    assign wr_data_count = wr_ptr - rd_word;

    // lanes written minus lanes read, modulo the wrap range
    assign rd_data_count = {wr_ptr, {LANE_BITS{1'b0}}} - rd_ptr;

    assign wr_data_space = WR_CNT_W'(WR_DEPTH) - wr_data_count;
    assign rd_data_space = RD_CNT_W'(RD_DEPTH) - rd_data_count;

    // storage write port
    assign ram.wr_en   = wr_accept;
    assign ram.wr_addr = wr_ptr[ADDR_W-1:0];
    assign ram.wr_data = din;

    // storage read port
    assign ram.rd_en   = rd_accept;
    assign ram.rd_addr = rd_ptr[RD_ADDR_W-1:LANE_BITS];

    // top lane goes out first, then downwards
    assign ram.rd_lane = lane_idx_t'(LANE_COUNT - 1) - rd_ptr[LANE_BITS-1:0];

endmodule

`default_nettype wire

/* hw/lane_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module lane_ram #(
    parameter int WR_DEPTH = 16
) (
    input  wire              clock,
    input  wire              sys_rst,

    output fifo_pkg::lane_t  dout,

    fifo_ram_if.ram          ram
);

    import fifo_pkg::*;

    localparam int ADDR_W = $clog2(WR_DEPTH);

    // one entry per wide word, depth is a power of two
    wide_word_t mem [2**ADDR_W];

    // word of the current read, selected by the control side
    wide_word_t rd_word;

    always_ff @(posedge clock) begin
        if (ram.wr_en) begin
            mem[ram.wr_addr] <= ram.wr_data;
        end
    end

    assign rd_word = mem[ram.rd_addr];

    // registered lane select, holds between reads
    always_ff @(posedge clock or negedge sys_rst) begin
        if (!sys_rst) begin
            dout <= '0;
        end else if (ram.rd_en) begin
            dout <= rd_word.lanes[ram.rd_lane];
        end
    end

endmodule

`default_nettype wire

/* hw/width_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module width_fifo #(
    parameter int WR_DEPTH = 16
) (
    input  wire                                               clock,
    input  wire                                               sys_rst,

    // write side, one wide word per accepted write
    input  wire                                               wr_en,
    input  fifo_pkg::wide_word_t                              din,
    output logic                                              wr_ready,

    // read side, one lane per accepted read
    input  wire                                               rd_en,
    output logic                                              valid,
    output fifo_pkg::lane_t                                   dout,

    output logic                                              full,
    output logic                                              empty,

    // counts in wide words on the write side, lanes on the read side
    output logic [$clog2(WR_DEPTH):0]                         wr_data_count,
    output logic [$clog2(WR_DEPTH):0]                         wr_data_space,
    output logic [$clog2(WR_DEPTH*fifo_pkg::LANE_COUNT):0]    rd_data_count,
    output logic [$clog2(WR_DEPTH*fifo_pkg::LANE_COUNT):0]    rd_data_space
);

    localparam int ADDR_W = $clog2(WR_DEPTH);

    fifo_ram_if #(
        .ADDR_WIDTH (ADDR_W)
    ) ram_bus ();

    fifo_ctrl #(
        .WR_DEPTH (WR_DEPTH)
    ) u_ctrl (
        .clock         (clock),
        .sys_rst       (sys_rst),
        .wr_en         (wr_en),
        .din           (din),
        .wr_ready      (wr_ready),
        .rd_en         (rd_en),
        .valid         (valid),
        .full          (full),
        .empty         (empty),
        .wr_data_count (wr_data_count),
        .wr_data_space (wr_data_space),
        .rd_data_count (rd_data_count),
        .rd_data_space (rd_data_space),
        .ram           (ram_bus.ctrl)
    );

    // storage with the output lane register
    lane_ram #(
        .WR_DEPTH (WR_DEPTH)
    ) u_ram (
        .clock   (clock),
        .sys_rst (sys_rst),
        .dout    (dout),
        .ram     (ram_bus.ram)
    );

endmodule

`default_nettype wire

/* tb/width_fifo_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module width_fifo_tb;

    import fifo_pkg::*;

    localparam int WR_DEPTH = 16;
    localparam int WCNT_W   = $clog2(WR_DEPTH) + 1;
    localparam int RCNT_W   = $clog2(WR_DEPTH * LANE_COUNT) + 1;

    logic              clock;
    logic              sys_rst;
    logic              wr_en;
    wide_word_t        din;
    logic              rd_en;
    logic              wr_ready;
    logic              valid;
    lane_t             dout;
    logic              full;
    logic              empty;
    logic [WCNT_W-1:0] wr_data_count;
    logic [WCNT_W-1:0] wr_data_space;
    logic [RCNT_W-1:0] rd_data_count;
    logic [RCNT_W-1:0] rd_data_space;

    // reference model state
    lane_t             model_q [$];
    int                wr_total;
    int                rd_total;
    logic              exp_valid;
    lane_t             exp_dout;

    logic [31:0]       lcg_state;
    int                errors;
    int                valid_seen;
    int                tests_run;
    int                tests_failed;
    int                test_err_start;
    string             test_name;

    width_fifo #(
        .WR_DEPTH (WR_DEPTH)
    ) dut (
        .clock         (clock),
        .sys_rst       (sys_rst),
        .wr_en         (wr_en),
        .din           (din),
        .wr_ready      (wr_ready),
        .rd_en         (rd_en),
        .valid         (valid),
        .dout          (dout),
        .full          (full),
        .empty         (empty),
        .wr_data_count (wr_data_count),
        .wr_data_space (wr_data_space),
        .rd_data_count (rd_data_count),
        .rd_data_space (rd_data_space)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] expv,
                                   input logic [31:0] actv);
        errors++;
        $display("Error at %0t: %s expected %0h, got %0h", $time, name, expv, actv);
    endtask

    task automatic check_eq(input string name, input logic [31:0] expv,
                            input logic [31:0] actv);
        assert (actv == expv) else report_mismatch(name, expv, actv);
    endtask

    // drive one cycle of inputs from a falling edge
    task automatic step(input logic we, input logic re, input logic [31:0] data);
        wr_en    = we;
        rd_en    = re;
        din.flat = data;
        @(negedge clock);
    endtask

    task automatic drain(input int limit);
        int n;
        n = 0;
        while (!empty && n < limit) begin
            step(1'b0, 1'b1, 32'h0);
            n++;
        end
        step(1'b0, 1'b0, 32'h0);
        if (!empty) begin
            errors++;
            $display("timeout: FIFO did not drain within %0d reads", limit);
        end
    endtask

    task automatic begin_test(input string name);
        test_name      = name;
        test_err_start = errors;
    endtask

    task automatic end_test();
        tests_run++;
        if (errors == test_err_start) begin
            $display("test %s: ok", test_name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", test_name, errors - test_err_start);
        end
    endtask

    // model follows the DUT flags as sampled before the edge
    always @(posedge clock or negedge sys_rst) begin : model_update
        int   i;
        logic wr_acc;
        logic rd_acc;
        if (!sys_rst) begin
            model_q.delete();
            wr_total  = 0;
            rd_total  = 0;
            exp_valid = 1'b0;
            exp_dout  = '0;
        end else begin
            wr_acc = wr_en && !full;
            rd_acc = rd_en && !empty;
            if (rd_acc && model_q.size() == 0) begin
                errors++;
                $display("read accepted at %0t while the model holds no data", $time);
            end else if (rd_acc) begin
                exp_dout = model_q.pop_front();
                rd_total++;
            end
            exp_valid = rd_acc;
            if (wr_acc) begin
                for (i = LANE_COUNT - 1; i >= 0; i--) begin
                    model_q.push_back(din.lanes[i]);
                end
                wr_total++;
            end
        end
    end

    // outputs are settled by the falling edge
    always @(negedge clock) begin : output_check
        int exp_wcnt;
        int exp_rcnt;
        if (sys_rst === 1'b1) begin
            exp_wcnt = wr_total - rd_total / LANE_COUNT;
            exp_rcnt = LANE_COUNT * wr_total - rd_total;
            check_eq("valid", 32'(exp_valid), 32'(valid));
            check_eq("dout", 32'(exp_dout), 32'(dout));
            check_eq("wr_data_count", 32'(exp_wcnt), 32'(wr_data_count));
            check_eq("wr_data_space", 32'(WR_DEPTH - exp_wcnt), 32'(wr_data_space));
            check_eq("rd_data_count", 32'(exp_rcnt), 32'(rd_data_count));
            check_eq("rd_data_space", 32'(WR_DEPTH * LANE_COUNT - exp_rcnt),
                     32'(rd_data_space));
            check_eq("full", 32'(exp_wcnt == WR_DEPTH), 32'(full));
            check_eq("wr_ready", 32'(exp_wcnt != WR_DEPTH), 32'(wr_ready));
            check_eq("empty", 32'(model_q.size() == 0), 32'(empty));
            if (valid) begin
                valid_seen++;
            end
        end
    end

    assert property (@(posedge clock) disable iff (!sys_rst)
                     full |-> wr_data_count == WCNT_W'(WR_DEPTH))
        else report_mismatch("wr_data_count", WR_DEPTH, 32'($sampled(wr_data_count)));

    initial begin : main
        int          n;
        int          seen_start;
        lane_t       held;
        logic [31:0] ctrl;
        logic [31:0] data;
        sys_rst      = 1'b0;
        wr_en        = 1'b0;
        rd_en        = 1'b0;
        din.flat     = '0;
        lcg_state    = 32'hf5ccce8a;
        errors       = 0;
        valid_seen   = 0;
        tests_run    = 0;
        tests_failed = 0;
        repeat (4) @(negedge clock);
        sys_rst = 1'b1;

        begin_test("reset state");
        check_eq("valid", 32'h0, 32'(valid));
        check_eq("full", 32'h0, 32'(full));
        check_eq("empty", 32'h1, 32'(empty));
        check_eq("wr_ready", 32'h1, 32'(wr_ready));
        check_eq("wr_data_count", 32'h0, 32'(wr_data_count));
        check_eq("rd_data_count", 32'h0, 32'(rd_data_count));
        check_eq("wr_data_space", WR_DEPTH, 32'(wr_data_space));
        check_eq("rd_data_space", WR_DEPTH * LANE_COUNT, 32'(rd_data_space));
        check_eq("dout", 32'h0, 32'(dout));
        end_test();

        begin_test("one word, four lanes");
        seen_start = valid_seen;
        step(1'b1, 1'b0, next_rand());
        repeat (LANE_COUNT) step(1'b0, 1'b1, 32'h0);
        step(1'b0, 1'b0, 32'h0);
        n = 0;
        while (valid_seen < seen_start + LANE_COUNT && n < 8) begin
            @(negedge clock);
            n++;
        end
        if (valid_seen != seen_start + LANE_COUNT) begin
            errors++;
            $display("timeout: saw %0d valid lanes instead of 4", valid_seen - seen_start);
        end
        check_eq("empty", 32'h1, 32'(empty));
        end_test();

        begin_test("fill and ignored write");
        n = 0;
        while (!full && n < 40) begin
            step(1'b1, 1'b0, next_rand());
            n++;
        end
        if (!full) begin
            errors++;
            $display("timeout: full never went high after %0d writes", n);
        end
        check_eq("wr_ready", 32'h0, 32'(wr_ready));
        step(1'b1, 1'b0, 32'ha5a55a5a);
        step(1'b0, 1'b0, 32'h0);
        check_eq("wr_data_count", WR_DEPTH, 32'(wr_data_count));
        drain(WR_DEPTH * LANE_COUNT + 8);
        end_test();

        begin_test("reads while empty");
        held = dout;
        repeat (4) step(1'b0, 1'b1, 32'h0);
        step(1'b0, 1'b0, 32'h0);
        check_eq("valid", 32'h0, 32'(valid));
        check_eq("dout", 32'(held), 32'(dout));
        end_test();

        begin_test("partial word counts");
        repeat (3) step(1'b1, 1'b0, next_rand());
        repeat (5) step(1'b0, 1'b1, 32'h0);
        check_eq("wr_data_count", 32'h2, 32'(wr_data_count));
        check_eq("rd_data_count", 32'h7, 32'(rd_data_count));
        step(1'b1, 1'b1, next_rand());
        repeat (2) step(1'b0, 1'b1, 32'h0);
        check_eq("wr_data_count", 32'h2, 32'(wr_data_count));
        check_eq("rd_data_count", 32'h8, 32'(rd_data_count));
        drain(WR_DEPTH * LANE_COUNT + 8);
        end_test();

        begin_test("random stream");
        for (n = 0; n < 400; n++) begin
            ctrl = next_rand();
            data = next_rand();
            step(ctrl[31:30] == 2'b00, ctrl[29:27] != 3'b000, data);
        end
        drain(WR_DEPTH * LANE_COUNT + 8);
        end_test();

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
hw/fifo_pkg.sv
hw/fifo_ram_if.sv
hw/fifo_ctrl.sv
hw/lane_ram.sv
hw/width_fifo.sv
tb/width_fifo_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing
TOP       = width_fifo_tb
FILELIST  = files.f
BUILD_DIR = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "=== PASS ==="

clean:
	rm -rf $(BUILD_DIR)
